//--- sim.f
hw/egr_pkg.sv
hw/egr_demux.sv
hw/egr_port_buffer.sv
hw/egr_width_adapt.sv
hw/egr_port_counters.sv
hw/p4_egress.sv
tb/tb_p4_egress.sv

//--- Makefile
TOP := tb_p4_egress

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^\*\*\* PASSED \*\*\*$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_p4_egress.sv
/* Directed testbench for the egress stage, with a credit-returning port model
   per port and a scoreboard of expected port beats built from the split rule. */

`timescale 1ns/10ps
`default_nettype none

module tb_p4_egress
    import egr_pkg::*;
();

    localparam int NUM_PORTS   = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int MTU_BYTES   = 64;
    localparam int CREDIT_INIT = 4;
    localparam int MTU_BEATS   = MTU_BYTES / EGR_BUS_BYTES;
    localparam int DRV_DLY     = 10;
    // About twenty packets of under 100 cycles each, with wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                 egr_bus;
    logic                 rst_n;
    logic                 egr_in_valid;
    egr_bus_beat_t        egr_in;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] credit_return;
    logic [NUM_PORTS-1:0] cnt_clear;
    logic [NUM_PORTS-1:0] port_valid;
    egr_port_beat_t       port_beat [NUM_PORTS];
    egr_port_cnts_t       cnts [NUM_PORTS];

    egr_port_beat_t       exp_q [NUM_PORTS][$];
    int unsigned          due_q [NUM_PORTS][$];
    egr_port_cnts_t       exp_cnt [NUM_PORTS];
    int                   outstanding [NUM_PORTS];
    logic [NUM_PORTS-1:0] paused;
    int unsigned          cycle;

    p4_egress #(
        .NUM_PORTS     ( NUM_PORTS     ),
        .FIFO_DEPTH    ( FIFO_DEPTH    ),
        .MTU_BYTES     ( MTU_BYTES     ),
        .CREDIT_INIT   ( CREDIT_INIT   )
    ) dut_i (
        .egr_bus       ( egr_bus       ),
        .rst_n         ( rst_n         ),
        .egr_in_valid  ( egr_in_valid  ),
        .egr_in        ( egr_in        ),
        .port_enable   ( port_enable   ),
        .credit_return ( credit_return ),
        .cnt_clear     ( cnt_clear     ),
        .port_valid    ( port_valid    ),
        .port_beat     ( port_beat     ),
        .cnts          ( cnts          )
    );

    initial begin
        egr_bus = 1'b0;
        forever #50 egr_bus = ~egr_bus;
    end

    //////////////////////////////////////////////////
    // Checks

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic check_port_beat(input string name, input egr_port_beat_t got,
                                   input egr_port_beat_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_cnts(input int p, input egr_port_cnts_t got,
                              input egr_port_cnts_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH cnts[%0d] got %h/%h/%h expected %h/%h/%h", p,
                got.accepted, got.dropped, got.sent, exp.accepted, exp.dropped, exp.sent));
        end
    endtask

    task automatic check_all_cnts();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_cnts(p, cnts[p], exp_cnt[p]);
        end
    endtask

    always @(posedge egr_bus) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, expected beats never came", cycle));
        end
    end

    //////////////////////////////////////////////////
    // Port model and scoreboard

    // A credit pulsed this cycle is not yet seen by the DUT
    always @(negedge egr_bus) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (port_valid[p] && exp_q[p].size() == 0) begin
                fail_run($sformatf("Port %0d sent a beat that no packet predicts", p));
            end else if (port_valid[p]) begin
                check_port_beat($sformatf("port_beat[%0d]", p), port_beat[p],
                                exp_q[p].pop_front());
                outstanding[p]++;
                if (outstanding[p] + int'(credit_return[p]) > CREDIT_INIT) begin
                    fail_run($sformatf("Port %0d sent more beats than it had credits", p));
                end
                due_q[p].push_back(cycle + $urandom_range(4, 1));
            end
        end
    end

    // One credit per port per cycle, held back while paused
    always @(posedge egr_bus) begin
        #DRV_DLY;
        for (int p = 0; p < NUM_PORTS; p++) begin
            credit_return[p] = 1'b0;
            if (!paused[p] && due_q[p].size() != 0 && due_q[p][0] <= cycle) begin
                void'(due_q[p].pop_front());
                outstanding[p]--;
                credit_return[p] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic step();
        @(posedge egr_bus);
        #DRV_DLY;
    endtask

    task automatic settle(input int n);
        repeat (n) step();
    endtask

    task automatic send_packet(input int port, input int nbytes, input bit expect_out);
        egr_bus_beat_t  beat;
        egr_port_beat_t pb;
        int             nbeats;
        int             nb;
        int             lanes;
        nbeats = (nbytes + EGR_BUS_BYTES - 1) / EGR_BUS_BYTES;
        for (int b = 0; b < nbeats; b++) begin
            nb = nbytes - b * EGR_BUS_BYTES;
            nb = (nb > EGR_BUS_BYTES) ? EGR_BUS_BYTES : nb;
            beat = '0;
            for (int i = 0; i < nb; i++) begin
                beat.data[i*8 +: 8] = 8'($urandom);
            end
            beat.keep        = EGR_BUS_BYTES'((1 << nb) - 1);
            beat.last        = (b == nbeats - 1);
            beat.egress_port = EGR_PORT_IDX_W'(port);
            // Lanes in byte order up to the last one holding data
            if (expect_out) begin
                lanes = (nb + EGR_PORT_BYTES - 1) / EGR_PORT_BYTES;
                for (int l = 0; l < lanes; l++) begin
                    pb.data = beat.data[l*16 +: 16];
                    pb.keep = beat.keep[l*2 +: 2];
                    pb.last = beat.last && (l == lanes - 1);
                    exp_q[port].push_back(pb);
                end
            end
            egr_in_valid = 1'b1;
            egr_in       = beat;
            step();
        end
        egr_in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            while (exp_q[p].size() != 0) begin
                step();
            end
        end
        settle(8);
    endtask

    //////////////////////////////////////////////////
    // Tests

    task automatic test_full_packets();
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_packet(p, MTU_BYTES, 1'b1);
            exp_cnt[p].accepted += 1;
            exp_cnt[p].sent     += 1;
        end
        wait_idle();
        check_all_cnts();
    endtask

    task automatic test_partial_tails();
        int len [4] = '{17, 19, 21, 24};
        for (int i = 0; i < 4; i++) begin
            send_packet(0, len[i], 1'b1);
            exp_cnt[0].accepted += 1;
            exp_cnt[0].sent     += 1;
        end
        wait_idle();
        check_all_cnts();
    endtask

    task automatic test_drops();
        port_enable[2] = 1'b0;
        send_packet(2, MTU_BYTES, 1'b0);
        send_packet(2, 10, 1'b0);
        exp_cnt[2].dropped += 2;
        send_packet(NUM_PORTS, 24, 1'b0);
        send_packet(200, 9, 1'b0);
        wait_idle();
        port_enable[2] = 1'b1;
        check_all_cnts();
    endtask

    task automatic test_backpressure();
        int n_pkts;
        int n_acc;
        // A stalled adapter drains less than one MTU, so only whole-MTU room counts
        n_acc  = FIFO_DEPTH / MTU_BEATS;
        n_pkts = n_acc + 2;
        paused[1] = 1'b1;
        for (int i = 0; i < n_pkts; i++) begin
            send_packet(1, MTU_BYTES, i < n_acc);
        end
        settle(8);
        exp_cnt[1].accepted += n_acc;
        exp_cnt[1].dropped  += n_pkts - n_acc;
        check_all_cnts();
        paused[1] = 1'b0;
        exp_cnt[1].sent += n_acc;
        wait_idle();
        check_all_cnts();
    endtask

    task automatic test_counter_clear();
        cnt_clear[2] = 1'b1;
        step();
        cnt_clear[2] = 1'b0;
        settle(2);
        exp_cnt[2] = '0;
        check_all_cnts();
    endtask

    initial begin
        void'($urandom(32'h5319_bc44));
        rst_n         = 1'b0;
        egr_in_valid  = 1'b0;
        egr_in        = '0;
        port_enable   = '1;
        credit_return = '0;
        cnt_clear     = '0;
        paused        = '0;
        cycle         = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_cnt[p]     = '0;
            outstanding[p] = 0;
        end
        settle(5);
        rst_n = 1'b1;
        settle(2);
        check_all_cnts();
        test_full_packets();
        test_partial_tails();
        test_drops();
        test_backpressure();
        test_counter_clear();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/p4_egress.sv
/* Egress stage top: demux, one buffer and width adapter per port, and
   the shared packet counters. Everything runs on egr_bus. */

`timescale 1ns/10ps
`default_nettype none

module p4_egress
    import egr_pkg::*;
#(
    parameter int NUM_PORTS   = 4,
    parameter int FIFO_DEPTH  = 16,
    parameter int MTU_BYTES   = 64,
    parameter int CREDIT_INIT = 4
)(
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  logic                 egr_in_valid,
    input  egr_bus_beat_t        egr_in,
    input  logic [NUM_PORTS-1:0] port_enable,
    input  logic [NUM_PORTS-1:0] credit_return,
    input  logic [NUM_PORTS-1:0] cnt_clear,
    output logic [NUM_PORTS-1:0] port_valid,
    output egr_port_beat_t       port_beat [NUM_PORTS],
    output egr_port_cnts_t       cnts [NUM_PORTS]
);

    logic [NUM_PORTS-1:0] wr_valid;
    logic                 wr_first;
    egr_bus_beat_t        wr_beat;
    logic [NUM_PORTS-1:0] rd_valid;
    logic [NUM_PORTS-1:0] rd_pop;
    egr_bus_beat_t        rd_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] ev_accept;
    logic [NUM_PORTS-1:0] ev_drop;
    logic [NUM_PORTS-1:0] ev_sent;

    //////////////////////////////////////////////////
    // Input steering

    egr_demux #(
        .NUM_PORTS    ( NUM_PORTS    )
    ) demux_i (
        .egr_bus      ( egr_bus      ),
        .rst_n        ( rst_n        ),
        .egr_in_valid ( egr_in_valid ),
        .egr_in       ( egr_in       ),
        .wr_valid     ( wr_valid     ),
        .wr_first     ( wr_first     ),
        .wr_beat      ( wr_beat      )
    );

    //////////////////////////////////////////////////
    // Per-port buffer and width adapter

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        egr_port_buffer #(
            .FIFO_DEPTH  ( FIFO_DEPTH     ),
            .MTU_BYTES   ( MTU_BYTES      )
        ) buf_i (
            .egr_bus     ( egr_bus        ),
            .rst_n       ( rst_n          ),
            .port_enable ( port_enable[p] ),
            .wr_valid    ( wr_valid[p]    ),
            .wr_first    ( wr_first       ),
            .wr_beat     ( wr_beat        ),
            .rd_pop      ( rd_pop[p]      ),
            .rd_valid    ( rd_valid[p]    ),
            .rd_beat     ( rd_beat[p]     ),
            .ev_accept   ( ev_accept[p]   ),
            .ev_drop     ( ev_drop[p]     )
        );

        egr_width_adapt #(
            .CREDIT_INIT   ( CREDIT_INIT      )
        ) adapt_i (
            .egr_bus       ( egr_bus          ),
            .rst_n         ( rst_n            ),
            .rd_valid      ( rd_valid[p]      ),
            .rd_beat       ( rd_beat[p]       ),
            .rd_pop        ( rd_pop[p]        ),
            .credit_return ( credit_return[p] ),
            .port_valid    ( port_valid[p]    ),
            .port_beat     ( port_beat[p]     ),
            .ev_sent       ( ev_sent[p]       )
        );
    end

    //////////////////////////////////////////////////
    // Counters

    egr_port_counters #(
        .NUM_PORTS ( NUM_PORTS )
    ) counters_i (
        .egr_bus   ( egr_bus   ),
        .rst_n     ( rst_n     ),
        .ev_accept ( ev_accept ),
        .ev_drop   ( ev_drop   ),
        .ev_sent   ( ev_sent   ),
        .cnt_clear ( cnt_clear ),
        .cnts      ( cnts      )
    );

endmodule

`default_nettype wire

//--- hw/egr_port_counters.sv
/* Accepted, dropped and sent packet counters for every port.
   Counters saturate, and a per-port clear beats any event that cycle. */

`timescale 1ns/10ps
`default_nettype none

module egr_port_counters
    import egr_pkg::*;
#(
    parameter int NUM_PORTS = 4
)(
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] ev_accept,
    input  logic [NUM_PORTS-1:0] ev_drop,
    input  logic [NUM_PORTS-1:0] ev_sent,
    input  logic [NUM_PORTS-1:0] cnt_clear,
    output egr_port_cnts_t       cnts [NUM_PORTS]
);

    function automatic logic [EGR_CNT_W-1:0] sat_inc(
        input logic [EGR_CNT_W-1:0] v,
        input logic                 ev
    );
        return (ev && (v != '1)) ? v + 1'b1 : v;
    endfunction

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                cnts[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cnt_clear[p]) begin
                    cnts[p] <= '0;
                end else begin
                    cnts[p].accepted <= sat_inc(cnts[p].accepted, ev_accept[p]);
                    cnts[p].dropped  <= sat_inc(cnts[p].dropped, ev_drop[p]);
                    cnts[p].sent     <= sat_inc(cnts[p].sent, ev_sent[p]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/egr_width_adapt.sv
/* Splits each wide beat into port beats, lane 0 first, and spends one
   credit per port beat sent. Credits come back on credit_return. */

`timescale 1ns/10ps
`default_nettype none

module egr_width_adapt
    import egr_pkg::*;
#(
    parameter int CREDIT_INIT = 4
)(
    input  logic           egr_bus,
    input  logic           rst_n,
    input  logic           rd_valid,
    input  egr_bus_beat_t  rd_beat,
    output logic           rd_pop,
    input  logic           credit_return,
    output logic           port_valid,
    output egr_port_beat_t port_beat,
    output logic           ev_sent
);

    localparam int LANE_W = $clog2(EGR_SPLIT);
    localparam int CRED_W = $clog2(CREDIT_INIT + 1);
    localparam int LANE_BITS = EGR_PORT_BYTES * 8;

    egr_bus_beat_t     hold_beat;
    logic              hold_valid;
    logic [LANE_W-1:0] lane;
    logic [LANE_W-1:0] last_lane;
    logic [CRED_W-1:0] credits;
    logic              send;
    logic              final_lane;

    // Highest lane with any keep bit set
    always_comb begin
        last_lane = '0;
        for (int l = 0; l < EGR_SPLIT; l++) begin
            if (|hold_beat.keep[l*EGR_PORT_BYTES +: EGR_PORT_BYTES]) begin
                last_lane = LANE_W'(l);
            end
        end
    end

    assign final_lane = (lane == last_lane);
    assign port_valid = hold_valid && (credits != '0);
    assign send       = port_valid;
    assign rd_pop     = rd_valid && (!hold_valid || (send && final_lane));

    assign port_beat.data = hold_beat.data[lane*LANE_BITS +: LANE_BITS];
    assign port_beat.keep = hold_beat.keep[lane*EGR_PORT_BYTES +: EGR_PORT_BYTES];
    assign port_beat.last = hold_beat.last && final_lane;
    assign ev_sent        = send && port_beat.last;

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            lane       <= '0;
            credits    <= CRED_W'(CREDIT_INIT);
        end else begin
            if (send) begin
                lane <= final_lane ? '0 : lane + 1'b1;
            end
            if (rd_pop) begin
                hold_valid <= 1'b1;
            end else if (send && final_lane) begin
                hold_valid <= 1'b0;
            end
            // Return while sending leaves the count as is
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= (credits < CRED_W'(CREDIT_INIT)) ? credits + 1'b1 : credits;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge egr_bus) begin
        if (rd_pop) begin
            hold_beat <= rd_beat;
        end
    end

    // The port returns no more credits than it was given
    a_credit_cap: assert property (@(posedge egr_bus) disable iff (!rst_n)
        credit_return |-> (credits < CRED_W'(CREDIT_INIT)));

endmodule

`default_nettype wire

//--- hw/egr_port_buffer.sv
/* Per-port packet FIFO holding wide beats. Admits or drops whole packets,
   deciding at the first beat from the port enable and free space. */

`timescale 1ns/10ps
`default_nettype none

module egr_port_buffer
    import egr_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int MTU_BYTES  = 64
)(
    input  logic          egr_bus,
    input  logic          rst_n,
    input  logic          port_enable,
    input  logic          wr_valid,
    input  logic          wr_first,
    input  egr_bus_beat_t wr_beat,
    input  logic          rd_pop,
    output logic          rd_valid,
    output egr_bus_beat_t rd_beat,
    output logic          ev_accept,
    output logic          ev_drop
);

    localparam int MTU_BEATS = (MTU_BYTES + EGR_BUS_BYTES - 1) / EGR_BUS_BYTES;
    localparam int PTR_W     = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W     = $clog2(FIFO_DEPTH + 1);

    egr_bus_beat_t    mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             drop_q;
    logic             drop_cur;
    logic             admit;
    logic             do_write;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Admission

    // Room for a full MTU packet, or drop it whole
    assign admit    = port_enable && ((FIFO_DEPTH - int'(count)) >= MTU_BEATS);
    assign drop_cur = wr_first ? !admit : drop_q;
    assign do_write = wr_valid && !drop_cur;

    assign ev_accept = wr_valid && wr_beat.last && !drop_cur;
    assign ev_drop   = wr_valid && wr_beat.last && drop_cur;

    //////////////////////////////////////////////////
    // Storage

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop_q <= 1'b0;
        end else begin
            if (wr_valid) begin
                drop_q <= drop_cur;
            end
            if (do_write) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_write, rd_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge egr_bus) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    assign rd_valid = (count != '0);
    assign rd_beat  = mem[rd_ptr];

    // Admission must keep every accepted packet in bounds
    a_no_write_full: assert property (@(posedge egr_bus) disable iff (!rst_n)
        do_write |-> (count != CNT_W'(FIFO_DEPTH)));

    a_no_pop_empty: assert property (@(posedge egr_bus) disable iff (!rst_n)
        rd_pop |-> rd_valid);

endmodule

`default_nettype wire

//--- hw/egr_demux.sv
/* Registers the wide input bus and steers each beat to one port buffer.
   Out-of-range egress ports get no write strobe. */

`timescale 1ns/10ps
`default_nettype none

module egr_demux
    import egr_pkg::*;
#(
    parameter int NUM_PORTS = 4
)(
    input  logic                 egr_bus,
    input  logic                 rst_n,
    input  logic                 egr_in_valid,
    input  egr_bus_beat_t        egr_in,
    output logic [NUM_PORTS-1:0] wr_valid,
    output logic                 wr_first,
    output egr_bus_beat_t        wr_beat
);

    logic [NUM_PORTS-1:0] hit;
    logic                 sop;

    // One-hot port decode
    for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_hit
        assign hit[i] = (egr_in.egress_port == EGR_PORT_IDX_W'(i));
    end

    always_ff @(posedge egr_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid <= '0;
            wr_first <= 1'b0;
            sop      <= 1'b1;
        end else begin
            wr_valid <= egr_in_valid ? hit : '0;
            wr_first <= egr_in_valid && sop;
            // Next beat opens a packet after a last
            if (egr_in_valid) begin
                sop <= egr_in.last;
            end
        end
    end

    always_ff @(posedge egr_bus) begin
        if (egr_in_valid) begin
            wr_beat <= egr_in;
        end
    end

endmodule

`default_nettype wire

//--- hw/egr_pkg.sv
/* Widths and beat types shared by the egress stage.
   Imported by every egress module and by the testbench. */

`default_nettype none

package egr_pkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int EGR_BUS_BYTES  = 8;
    localparam int EGR_PORT_BYTES = 2;
    localparam int EGR_SPLIT      = EGR_BUS_BYTES / EGR_PORT_BYTES;
    localparam int EGR_PORT_IDX_W = 8;
    localparam int EGR_CNT_W      = 32;

    //////////////////////////////////////////////////
    // Beats

    // Keep is contiguous from byte 0, partial only on last
    typedef struct packed {
        logic [EGR_BUS_BYTES*8-1:0]  data;
        logic [EGR_BUS_BYTES-1:0]    keep;
        logic                        last;
        logic [EGR_PORT_IDX_W-1:0]   egress_port;
    } egr_bus_beat_t;

    typedef struct packed {
        logic [EGR_PORT_BYTES*8-1:0] data;
        logic [EGR_PORT_BYTES-1:0]   keep;
        logic                        last;
    } egr_port_beat_t;

    //////////////////////////////////////////////////
    // Counters

    typedef struct packed {
        logic [EGR_CNT_W-1:0] accepted;
        logic [EGR_CNT_W-1:0] dropped;
        logic [EGR_CNT_W-1:0] sent;
    } egr_port_cnts_t;

endpackage

`default_nettype wire
